/* soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ram window
`define RAM_BASE      32'h0000_1000
`define RAM_WORDS     1024
`define RAM_BYTES     (`RAM_WORDS * 4)

// sd sector window and its registers
`define SECTOR_BYTES  512
`define SD_BUF_BASE   32'h0000_2000
`define SD_ADDR_REG   32'h0000_2200
`define SD_START_REG  32'h0000_2208
`define SD_READY_REG  32'h0000_2210

// keyboard and console registers
`define KEY_ADDR      32'h0000_3000
`define TX_ADDR       32'h0000_3008

// console sink credits after reset
`define TX_CREDITS    4

`endif

/* soc_bus_pkg.sv */
package soc_bus_pkg;

    // byte address on the master bus
    typedef logic [31:0] bus_addr_t;

    // load and store data, always 64 bits wide
    typedef logic [63:0] bus_data_t;

    // access width, master aligns to the size
    typedef enum logic [1:0] {
        size_byte   = 2'd0,
        size_half   = 2'd1,
        size_word   = 2'd2,
        size_double = 2'd3
    } access_size_t;

    // extension applied to narrow loads
    typedef enum logic {
        kind_signed   = 1'b0,
        kind_unsigned = 1'b1
    } load_kind_t;

endpackage

/* soc_dev_pkg.sv */
package soc_dev_pkg;

    // target of the access currently in flight
    typedef enum logic [2:0] {
        dev_none     = 3'd0,
        dev_ram      = 3'd1,
        dev_key      = 3'd2,
        dev_tx       = 3'd3,
        dev_sd_addr  = 3'd4,
        dev_sd_start = 3'd5,
        dev_sd_ready = 3'd6,
        dev_sd_buf   = 3'd7
    } dev_sel_t;

    // keyboard codes, sd stream and console bytes
    typedef logic [7:0] byte_t;

endpackage

/* dev_if.sv */
interface dev_if
    import soc_bus_pkg::*;
#(
    parameter type rdata_t = logic [31:0]
) ();

    logic         req;
    logic         we;
    // byte offset from the device base
    bus_addr_t    offset;
    access_size_t size;
    bus_data_t    wdata;
    // second word of a two-beat access
    logic         beat;
    rdata_t       rdata;
    logic         ack;

    modport ctrl (
        output req, we, offset, size, wdata, beat,
        input  rdata, ack
    );

    modport dev (
        input  req, we, offset, size, wdata, beat,
        output rdata, ack
    );

endinterface

/* bus_ctrl.sv */
`include "soc_config.svh"

module bus_ctrl
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         KEY0,
    input  bus_addr_t    bus_addr,
    input  bus_data_t    bus_wdata,
    input  logic         bus_rd,
    input  logic         bus_wr,
    input  access_size_t bus_size,
    input  load_kind_t   bus_kind,
    output bus_data_t    bus_rdata,
    output logic         bus_done,
    dev_if.ctrl          ram,
    dev_if.ctrl          sdc,
    dev_if.ctrl          con
);

    typedef enum logic [1:0] {
        st_idle,
        st_beat0,
        st_beat1,
        st_wait
    } state_t;

    state_t       state;
    bus_addr_t    addr_q;
    bus_data_t    wdata_q;
    access_size_t size_q;
    load_kind_t   kind_q;
    logic         we_q;
    dev_sel_t     sel_q;
    logic [31:0]  lo_q;

    logic         accept;
    logic         beat_active;
    logic         two_beat;
    logic         sd_sel;
    logic         con_sel;
    logic         dev_ack;
    bus_data_t    sd_group;
    bus_data_t    result;

    function automatic dev_sel_t decode(input bus_addr_t a);
        if (a >= `RAM_BASE && a < `RAM_BASE + `RAM_BYTES) begin
            return dev_ram;
        end else if (a >= `SD_BUF_BASE && a < `SD_BUF_BASE + `SECTOR_BYTES) begin
            return dev_sd_buf;
        end else if (a == `KEY_ADDR) begin
            return dev_key;
        end else if (a == `TX_ADDR) begin
            return dev_tx;
        end else if (a == `SD_ADDR_REG) begin
            return dev_sd_addr;
        end else if (a == `SD_START_REG) begin
            return dev_sd_start;
        end else if (a == `SD_READY_REG) begin
            return dev_sd_ready;
        end
        return dev_none;
    endfunction

    // raw holds the addressed lane in its low bits
    function automatic bus_data_t extend(input bus_data_t raw, input access_size_t sz,
                                         input load_kind_t kind);
        logic sgn;
        sgn = (kind == kind_signed);
        case (sz)
            size_byte: return {{56{sgn & raw[7]}}, raw[7:0]};
            size_half: return {{48{sgn & raw[15]}}, raw[15:0]};
            size_word: return {{32{sgn & raw[31]}}, raw[31:0]};
            default:   return raw;
        endcase
    endfunction

    assign accept      = bus_done && (bus_rd || bus_wr);
    assign beat_active = (state == st_beat0) || (state == st_beat1);
    assign two_beat    = (sel_q == dev_ram) && (size_q == size_double);
    assign sd_sel      = sel_q inside {dev_sd_addr, dev_sd_start, dev_sd_ready, dev_sd_buf};
    assign con_sel     = (sel_q == dev_key) || (sel_q == dev_tx);
    assign sd_group    = sdc.rdata;

    // one req cycle per beat; console req stays up until it acks
    assign ram.req = beat_active && (sel_q == dev_ram);
    assign sdc.req = beat_active && sd_sel;
    assign con.req = con_sel && ((state == st_beat0) || (state == st_wait && !con.ack));

    assign ram.beat = (state == st_beat1);
    assign sdc.beat = 1'b0;
    assign con.beat = 1'b0;

    assign ram.we = we_q;
    assign sdc.we = we_q;
    assign con.we = we_q;

    assign ram.size = size_q;
    assign sdc.size = size_q;
    assign con.size = size_q;

    assign ram.wdata = wdata_q;
    assign sdc.wdata = wdata_q;
    assign con.wdata = wdata_q;

    assign ram.offset = addr_q - `RAM_BASE;
    assign sdc.offset = addr_q - `SD_BUF_BASE;
    assign con.offset = addr_q - `KEY_ADDR;

    always_comb begin
        case (sel_q)
            dev_none:        dev_ack = 1'b1;
            dev_ram:         dev_ack = ram.ack;
            dev_key, dev_tx: dev_ack = con.ack;
            default:         dev_ack = sdc.ack;
        endcase
    end

    always_comb begin
        result = '0;
        case (sel_q)
            dev_none: result = '0;
            dev_ram: begin
                if (size_q == size_double) begin
                    result = {ram.rdata, lo_q};
                end else begin
                    result = extend(bus_data_t'(ram.rdata >> {addr_q[1:0], 3'b000}),
                                    size_q, kind_q);
                end
            end
            // key code is returned zero-extended
            dev_key, dev_tx: result = bus_data_t'(con.rdata);
            default: result = extend(sd_group >> {addr_q[2:0], 3'b000}, size_q, kind_q);
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state    <= st_idle;
            bus_done <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_beat0;
                        bus_done <= 1'b0;
                    end
                end
                st_beat0: state <= two_beat ? st_beat1 : st_wait;
                st_beat1: state <= st_wait;
                st_wait: begin
                    if (dev_ack) begin
                        state    <= st_idle;
                        bus_done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == st_idle && accept) begin
            addr_q  <= bus_addr;
            wdata_q <= bus_wdata;
            size_q  <= bus_size;
            kind_q  <= bus_kind;
            we_q    <= bus_wr;
            sel_q   <= decode(bus_addr);
        end
        // low word of a doubleword arrives while beat1 is on the bus
        if (state == st_beat1) begin
            lo_q <= ram.rdata;
        end
        if (state == st_wait && dev_ack && !we_q) begin
            bus_rdata <= result;
        end
    end

endmodule

/* ram_bank.sv */
`include "soc_config.svh"

module ram_bank
    import soc_bus_pkg::*;
(
    input logic CLOCK_50,
    dev_if.dev  ram
);

    localparam int addr_w = $clog2(`RAM_WORDS);

    // block ram, one 32-bit word per entry, little-endian lanes
    logic [31:0]       mem [0:`RAM_WORDS-1];
    logic [addr_w-1:0] word_idx;
    logic [3:0]        lane_en;
    logic [31:0]       lane_data;

    // doubleword offsets are 8-aligned, so beat picks the upper word
    assign word_idx = ram.offset[addr_w+1:2] + addr_w'(ram.beat);

    always_comb begin
        case (ram.size)
            size_byte: begin
                lane_en   = 4'b0001 << ram.offset[1:0];
                lane_data = {4{ram.wdata[7:0]}};
            end
            size_half: begin
                lane_en   = 4'b0011 << ram.offset[1:0];
                lane_data = {2{ram.wdata[15:0]}};
            end
            size_word: begin
                lane_en   = 4'b1111;
                lane_data = ram.wdata[31:0];
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = ram.beat ? ram.wdata[63:32] : ram.wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        ram.ack <= ram.req;
        if (ram.req) begin
            if (ram.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (lane_en[i]) begin
                        mem[word_idx][8*i +: 8] <= lane_data[8*i +: 8];
                    end
                end
            end
            // full word back, lane selection is done by the controller
            ram.rdata <= mem[word_idx];
        end
    end

endmodule

/* sector_buffer.sv */
`include "soc_config.svh"

module sector_buffer
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        KEY0,
    dev_if.dev          sdc,
    input  byte_t       sd_byte,
    input  logic        sd_byte_valid,
    output logic        sd_rd_start,
    output logic [31:0] sd_sector
);

    // register offsets relative to the buffer base
    localparam bus_addr_t off_addr  = `SD_ADDR_REG - `SD_BUF_BASE;
    localparam bus_addr_t off_start = `SD_START_REG - `SD_BUF_BASE;
    localparam bus_addr_t off_ready = `SD_READY_REG - `SD_BUF_BASE;

    byte_t       buffer [0:`SECTOR_BYTES-1];
    logic [9:0]  idx;
    logic        sector_ready;
    logic        start_wr;
    logic        fill;

    assign start_wr = sdc.req && sdc.we && (sdc.offset == off_start);
    // bytes past the end of a sector are dropped
    assign fill     = sd_byte_valid && (idx < 10'(`SECTOR_BYTES)) && !start_wr;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            idx          <= '0;
            sector_ready <= 1'b0;
            sd_rd_start  <= 1'b0;
            sd_sector    <= '0;
            sdc.ack      <= 1'b0;
        end else begin
            sdc.ack     <= sdc.req;
            sd_rd_start <= start_wr;
            if (sdc.req && sdc.we && sdc.offset == off_addr) begin
                sd_sector <= sdc.wdata[31:0];
            end
            if (start_wr) begin
                idx          <= '0;
                sector_ready <= 1'b0;
            end else if (fill) begin
                idx <= idx + 10'd1;
                if (idx == 10'(`SECTOR_BYTES - 1)) begin
                    sector_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (fill) begin
            buffer[idx[8:0]] <= sd_byte;
        end
        if (sdc.req && !sdc.we) begin
            if (sdc.offset == off_ready) begin
                sdc.rdata <= 64'(sector_ready);
            end else if (sdc.offset == off_addr) begin
                sdc.rdata <= 64'(sd_sector);
            end else if (sdc.offset < `SECTOR_BYTES) begin
                // eight bytes from the aligned group
                for (int i = 0; i < 8; i++) begin
                    sdc.rdata[i] <= buffer[{sdc.offset[8:3], 3'(i)}];
                end
            end else begin
                sdc.rdata <= '0;
            end
        end
    end

endmodule

/* console_port.sv */
`include "soc_config.svh"

module console_port
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;
(
    input  logic  CLOCK_50,
    input  logic  KEY0,
    dev_if.dev    con,
    input  byte_t key_code,
    input  logic  key_strobe,
    output logic  irq,
    input  logic  irq_ack,
    output byte_t tx_data,
    output logic  tx_valid,
    input  logic  tx_credit
);

    localparam bus_addr_t off_tx = `TX_ADDR - `KEY_ADDR;
    localparam int cred_w = $clog2(`TX_CREDITS + 1);

    byte_t             key_reg;
    logic [cred_w-1:0] credits;
    logic              tx_wr;
    logic              tx_go;
    logic              accept;

    assign tx_wr  = con.req && con.we && (con.offset == off_tx);
    // a transmit write waits here until a credit is on hand
    assign tx_go  = tx_wr && (credits != '0);
    assign accept = con.req && (!tx_wr || tx_go);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_reg  <= '0;
            irq      <= 1'b0;
            credits  <= cred_w'(`TX_CREDITS);
            tx_valid <= 1'b0;
            con.ack  <= 1'b0;
        end else begin
            con.ack  <= accept;
            tx_valid <= tx_go;
            if (key_strobe) begin
                key_reg <= key_code;
                irq     <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
            // net change of send and returning credit
            case ({tx_go, tx_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits < cred_w'(`TX_CREDITS)) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (tx_go) begin
            tx_data <= con.wdata[7:0];
        end
        if (con.req && !con.we) begin
            con.rdata <= (con.offset == off_tx) ? 8'h00 : key_reg;
        end
    end

endmodule

/* soc_bus_top.sv */
module soc_bus_top
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         KEY0,
    // master bus
    input  bus_addr_t    bus_addr,
    input  bus_data_t    bus_wdata,
    input  logic         bus_rd,
    input  logic         bus_wr,
    input  access_size_t bus_size,
    input  load_kind_t   bus_kind,
    output bus_data_t    bus_rdata,
    output logic         bus_done,
    // keyboard
    input  byte_t        key_code,
    input  logic         key_strobe,
    output logic         irq,
    input  logic         irq_ack,
    // sd stream
    input  byte_t        sd_byte,
    input  logic         sd_byte_valid,
    output logic         sd_rd_start,
    output logic [31:0]  sd_sector,
    // console sink
    output byte_t        tx_data,
    output logic         tx_valid,
    input  logic         tx_credit
);

    dev_if #(.rdata_t(logic [31:0])) ram_bus ();
    dev_if #(.rdata_t(byte_t [7:0])) sd_bus ();
    dev_if #(.rdata_t(byte_t))       con_bus ();

    bus_ctrl u_ctrl (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rd    (bus_rd),
        .bus_wr    (bus_wr),
        .bus_size  (bus_size),
        .bus_kind  (bus_kind),
        .bus_rdata (bus_rdata),
        .bus_done  (bus_done),
        .ram       (ram_bus.ctrl),
        .sdc       (sd_bus.ctrl),
        .con       (con_bus.ctrl)
    );

    ram_bank u_ram (
        .CLOCK_50 (CLOCK_50),
        .ram      (ram_bus.dev)
    );

    sector_buffer u_sd (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .sdc           (sd_bus.dev),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .sd_rd_start   (sd_rd_start),
        .sd_sector     (sd_sector)
    );

    console_port u_con (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .con        (con_bus.dev),
        .key_code   (key_code),
        .key_strobe (key_strobe),
        .irq        (irq),
        .irq_ack    (irq_ack),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_credit  (tx_credit)
    );

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 5
) (
    output logic CLOCK_50,
    output logic KEY0
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLOCK_50 = 1'b0;
        forever #(period / 2) CLOCK_50 = ~CLOCK_50;
    end

    // reset held low across the first rising edges
    initial begin
        KEY0 = 1'b0;
        repeat (reset_cycles) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
    end

endmodule

/* tb_soc_bus.sv */
`include "soc_config.svh"

module tb_soc_bus
    import soc_bus_pkg::*;
    import soc_dev_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ram_rand_ops = 400;
    localparam int key_rounds   = 8;
    localparam int tx_burst     = 20;
    localparam int unmapped_ops = 8;
    localparam int total_ops = `TX_CREDITS + 1 + 2 * (`RAM_BYTES / 8) + ram_rand_ops
                               + 3 * key_rounds + 6 + `SECTOR_BYTES + `SECTOR_BYTES / 8
                               + tx_burst + 2 * unmapped_ops;

    logic         CLOCK_50;
    logic         KEY0;
    bus_addr_t    bus_addr;
    bus_data_t    bus_wdata;
    logic         bus_rd;
    logic         bus_wr;
    access_size_t bus_size;
    load_kind_t   bus_kind;
    bus_data_t    bus_rdata;
    logic         bus_done;
    byte_t        key_code;
    logic         key_strobe;
    logic         irq;
    logic         irq_ack;
    byte_t        sd_byte;
    logic         sd_byte_valid;
    logic         sd_rd_start;
    logic [31:0]  sd_sector;
    byte_t        tx_data;
    logic         tx_valid;
    logic         tx_credit;

    // reference state
    byte_t        ram_model [0:`RAM_BYTES-1];
    byte_t        sd_model [0:`SECTOR_BYTES-1];
    byte_t        tx_expect [$];
    logic         sink_enable;
    int           start_pulses = 0;
    logic [31:0]  last_sector;

    tb_clock_gen #(.period(20), .reset_cycles(5)) u_clk (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0)
    );

    soc_bus_top DUT (.*);

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // called 2 ns after an edge with bus_done high
    task automatic access(input bus_addr_t addr, input bus_data_t wdata, input logic wr,
                          input access_size_t size, input load_kind_t kind,
                          output bus_data_t rdata, output int cycles);
        check_value("bus idle before issue", 1, bus_done);
        bus_addr  = addr;
        bus_wdata = wdata;
        bus_rd    = !wr;
        bus_wr    = wr;
        bus_size  = size;
        bus_kind  = kind;
        @(posedge CLOCK_50);
        #2;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        cycles = 0;
        do begin
            @(posedge CLOCK_50);
            #2;
            cycles++;
        end while (!bus_done);
        rdata = bus_rdata;
    endtask

    // little-endian bytes extended by size and kind
    function automatic bus_data_t model_load(input int unsigned off, input access_size_t size,
                                             input load_kind_t kind);
        int        nbytes;
        bus_data_t v;
        nbytes = 1 << size;
        v = '0;
        for (int i = nbytes - 1; i >= 0; i--) begin
            v = (v << 8) | bus_data_t'(ram_model[off + i]);
        end
        if (kind == kind_signed && nbytes < 8 && v[8 * nbytes - 1]) begin
            v = v | (~64'd0 << (8 * nbytes));
        end
        return v;
    endfunction

    function automatic logic is_mapped(input bus_addr_t a);
        return (a >= `RAM_BASE && a < `RAM_BASE + `RAM_BYTES) ||
               (a >= `SD_BUF_BASE && a <= `SD_READY_REG) ||
               (a >= `KEY_ADDR && a <= `TX_ADDR);
    endfunction

    // console sink with credit return and sd start monitor
    initial begin : console_sink
        int unsigned now;
        int unsigned due [$];
        int          outstanding;
        int          pick;
        now = 0;
        outstanding = 0;
        tx_credit = 1'b0;
        forever begin
            @(posedge CLOCK_50);
            #1;
            now++;
            if (tx_valid) begin
                check_value("tx send within credits", 1, outstanding < `TX_CREDITS);
                check_value("tx byte was pending", 1, tx_expect.size() != 0);
                check_value("tx data order", tx_expect.pop_front(), tx_data);
                due.push_back(now + $urandom_range(15, 0));
                outstanding++;
            end
            if (tx_credit) begin
                outstanding--;
            end
            if (sd_rd_start) begin
                start_pulses++;
                last_sector = sd_sector;
            end
            pick = -1;
            if (sink_enable) begin
                foreach (due[i]) begin
                    if (pick < 0 && due[i] <= now) begin
                        pick = i;
                    end
                end
            end
            #1;
            tx_credit = 1'b0;
            if (pick >= 0) begin
                due.delete(pick);
                tx_credit = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (total_ops * 40) @(posedge CLOCK_50);
        $display("timeout: run did not finish within %0d cycles", total_ops * 40);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        bus_data_t    rdata;
        bus_data_t    wdata;
        bus_data_t    expect_v;
        int           cycles;
        int unsigned  off;
        access_size_t size;
        load_kind_t   kind;
        logic         wr;
        bus_addr_t    addr;
        logic [31:0]  sector;
        byte_t        key_val;
        int           pulses_before;

        void'($urandom(32'h9191_dc6d));
        bus_addr      = '0;
        bus_wdata     = '0;
        bus_rd        = 1'b0;
        bus_wr        = 1'b0;
        bus_size      = size_byte;
        bus_kind      = kind_unsigned;
        key_code      = '0;
        key_strobe    = 1'b0;
        irq_ack       = 1'b0;
        sd_byte       = '0;
        sd_byte_valid = 1'b0;
        sink_enable   = 1'b0;

        @(posedge KEY0);
        @(posedge CLOCK_50);
        #2;

        // reset state
        check_value("reset bus_done", 1, bus_done);
        check_value("reset tx_valid", 0, tx_valid);
        check_value("reset irq", 0, irq);
        check_value("reset sd_rd_start", 0, sd_rd_start);

        // initial credits cover the first sends before back-pressure
        for (int i = 0; i < `TX_CREDITS; i++) begin
            tx_expect.push_back(byte_t'($urandom));
            access(`TX_ADDR, bus_data_t'(tx_expect[tx_expect.size() - 1]), 1'b1,
                   size_byte, kind_unsigned, rdata, cycles);
            check_value("tx write with credit cycles", 2, cycles);
        end
        tx_expect.push_back(byte_t'($urandom));
        bus_addr  = `TX_ADDR;
        bus_wdata = bus_data_t'(tx_expect[tx_expect.size() - 1]);
        bus_wr    = 1'b1;
        bus_size  = size_byte;
        @(posedge CLOCK_50);
        #2;
        bus_wr = 1'b0;
        repeat (10) begin
            @(posedge CLOCK_50);
            #2;
            check_value("tx write held without credit", 0, bus_done);
        end
        sink_enable = 1'b1;
        while (!bus_done) begin
            @(posedge CLOCK_50);
            #2;
        end
        check_value("tx queue drained", 0, tx_expect.size());

        // fill the ram with random doublewords
        for (int w = 0; w < `RAM_BYTES / 8; w++) begin
            wdata = {$urandom, $urandom};
            for (int b = 0; b < 8; b++) begin
                ram_model[w * 8 + b] = wdata[8 * b +: 8];
            end
            access(`RAM_BASE + w * 8, wdata, 1'b1, size_double, kind_unsigned, rdata, cycles);
            check_value("ram fill cycles", 3, cycles);
        end

        // random ram stores and loads
        for (int n = 0; n < ram_rand_ops; n++) begin
            size  = access_size_t'($urandom_range(3, 0));
            kind  = load_kind_t'($urandom_range(1, 0));
            wr    = $urandom_range(1, 0);
            off   = ($urandom % `RAM_BYTES) & ~((1 << size) - 1);
            wdata = {$urandom, $urandom};
            access(`RAM_BASE + off, wdata, wr, size, kind, rdata, cycles);
            check_value("ram access cycles", (size == size_double) ? 3 : 2, cycles);
            if (wr) begin
                for (int b = 0; b < (1 << size); b++) begin
                    ram_model[off + b] = wdata[8 * b +: 8];
                end
            end else begin
                check_value("ram load data", model_load(off, size, kind), rdata);
            end
        end

        // keyboard register and irq
        for (int n = 0; n < key_rounds; n++) begin
            key_val    = byte_t'($urandom);
            key_code   = key_val;
            key_strobe = 1'b1;
            @(posedge CLOCK_50);
            #2;
            key_strobe = 1'b0;
            check_value("irq after strobe", 1, irq);
            access(`KEY_ADDR, '0, 1'b0, size_word, kind_unsigned, rdata, cycles);
            check_value("key code read", bus_data_t'(key_val), rdata);
            irq_ack = 1'b1;
            @(posedge CLOCK_50);
            #2;
            irq_ack = 1'b0;
            check_value("irq after ack", 0, irq);
        end
        // strobe wins over a same-cycle ack
        key_strobe = 1'b1;
        irq_ack    = 1'b1;
        @(posedge CLOCK_50);
        #2;
        key_strobe = 1'b0;
        irq_ack    = 1'b0;
        check_value("irq strobe over ack", 1, irq);
        irq_ack = 1'b1;
        @(posedge CLOCK_50);
        #2;
        irq_ack = 1'b0;
        check_value("irq cleared", 0, irq);

        // sd sector read
        sector = $urandom;
        access(`SD_ADDR_REG, bus_data_t'(sector), 1'b1, size_word, kind_unsigned, rdata, cycles);
        pulses_before = start_pulses;
        access(`SD_START_REG, '0, 1'b1, size_word, kind_unsigned, rdata, cycles);
        check_value("sd start pulses", pulses_before + 1, start_pulses);
        check_value("sd start sector", sector, last_sector);
        access(`SD_READY_REG, '0, 1'b0, size_double, kind_unsigned, rdata, cycles);
        check_value("sd ready before stream", 0, rdata);
        for (int i = 0; i < `SECTOR_BYTES; i++) begin
            if (i == `SECTOR_BYTES / 2) begin
                access(`SD_READY_REG, '0, 1'b0, size_double, kind_unsigned, rdata, cycles);
                check_value("sd ready mid stream", 0, rdata);
            end
            if ($urandom_range(3, 0) == 0) begin
                @(posedge CLOCK_50);
                #2;
            end
            sd_model[i]   = byte_t'($urandom);
            sd_byte       = sd_model[i];
            sd_byte_valid = 1'b1;
            @(posedge CLOCK_50);
            #2;
            sd_byte_valid = 1'b0;
        end
        access(`SD_READY_REG, '0, 1'b0, size_double, kind_unsigned, rdata, cycles);
        check_value("sd ready after stream", 1, rdata);
        for (int g = 0; g < `SECTOR_BYTES / 8; g++) begin
            expect_v = '0;
            for (int b = 7; b >= 0; b--) begin
                expect_v = (expect_v << 8) | bus_data_t'(sd_model[g * 8 + b]);
            end
            access(`SD_BUF_BASE + g * 8, '0, 1'b0, size_double, kind_unsigned, rdata, cycles);
            check_value("sd buffer doubleword", expect_v, rdata);
        end
        check_value("sd single start pulse", pulses_before + 1, start_pulses);

        // console burst under flow control
        for (int n = 0; n < tx_burst; n++) begin
            tx_expect.push_back(byte_t'($urandom));
            access(`TX_ADDR, bus_data_t'(tx_expect[tx_expect.size() - 1]), 1'b1,
                   size_byte, kind_unsigned, rdata, cycles);
        end
        check_value("tx burst drained", 0, tx_expect.size());

        // unmapped reads give zero and writes are dropped
        for (int n = 0; n < unmapped_ops; n++) begin
            do begin
                addr = $urandom & 32'h0000_fff8;
            end while (is_mapped(addr));
            size = access_size_t'($urandom_range(3, 0));
            kind = load_kind_t'($urandom_range(1, 0));
            access(addr, '0, 1'b0, size, kind, rdata, cycles);
            check_value("unmapped read data", 0, rdata);
            check_value("unmapped read cycles", 2, cycles);
            access(addr, {$urandom, $urandom}, 1'b1, size_double, kind, rdata, cycles);
            check_value("unmapped write cycles", 2, cycles);
        end
        for (int w = 0; w < `RAM_BYTES / 8; w++) begin
            access(`RAM_BASE + w * 8, '0, 1'b0, size_double, kind_unsigned, rdata, cycles);
            check_value("ram after unmapped writes", model_load(w * 8, size_double,
                        kind_unsigned), rdata);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
soc_bus_pkg.sv
soc_dev_pkg.sv
dev_if.sv
bus_ctrl.sv
ram_bank.sv
sector_buffer.sv
console_port.sv
soc_bus_top.sv
tb_clock_gen.sv
tb_soc_bus.sv
